// File: logic/vcache_pkg.sv
// ####################################################################
// vcache tile shared definitions: widths, enums and packet layouts
// ####################################################################
package vcache_pkg;

  localparam int addr_width_c = 16;
  localparam int data_width_c = 32;
  localparam int x_cord_width_c = 4, y_cord_width_c = 3;
  localparam int wh_cord_width_c = 4;
  localparam int wh_cid_width_c = 2;
  localparam int wh_len_width_c = 4;

  typedef enum logic {
    e_load,
    e_store
  } link_op_e;

  // request on the vertical link
  typedef struct packed {
    logic                      v;
    link_op_e                  op;
    logic [addr_width_c-1:0]   addr;
    logic [data_width_c-1:0]   data;
    logic [x_cord_width_c-1:0] src_x;
    logic [y_cord_width_c-1:0] src_y;
  } link_pkt_s;

  typedef struct packed {
    logic                      v;
    logic [data_width_c-1:0]   data;
    logic [x_cord_width_c-1:0] dst_x;
    logic [y_cord_width_c-1:0] dst_y;
  } link_rsp_s;

  typedef struct packed {
    link_op_e                op;
    logic [addr_width_c-1:0] addr;
    logic [data_width_c-1:0] data;
  } cache_pkt_s;

  typedef struct packed {
    logic                    write_not_read;
    logic [addr_width_c-1:0] addr;
  } dma_pkt_s;

  // header flit, fills one data word
  typedef struct packed {
    logic [wh_cord_width_c-1:0] dest_cord;
    logic [wh_len_width_c-1:0]  len;
    logic [wh_cid_width_c-1:0]  cid;
    logic                       write_not_read;
    logic [data_width_c-wh_cord_width_c-wh_len_width_c-wh_cid_width_c-2:0] pad;
  } wh_hdr_s;

  typedef enum logic [2:0] {
    e_idle, e_lookup, e_writeback,
    e_fill, e_respond
  } cache_state_e;

endpackage

// File: logic/vcache_tile_ctrl.sv
// ####################################################################
// tile control: registered reset, coordinate feedthrough, cid
// ####################################################################
`timescale 1ns/1ps

module vcache_tile_ctrl (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic [vcache_pkg::x_cord_width_c-1:0] global_x_i,
  input  logic [vcache_pkg::y_cord_width_c-1:0] global_y_i,
  output logic                                  reset_r_o,
  output logic                                  reset_o,
  output logic [vcache_pkg::x_cord_width_c-1:0] global_x_r_o,
  output logic [vcache_pkg::y_cord_width_c-1:0] global_y_r_o,
  output logic [vcache_pkg::x_cord_width_c-1:0] global_x_o,
  output logic [vcache_pkg::y_cord_width_c-1:0] global_y_o,
  output logic [vcache_pkg::wh_cid_width_c-1:0] my_cid_o
);
  import vcache_pkg::*;

  always_ff @(posedge clk_i) begin
    reset_r_o    <= rst_i;
    global_x_r_o <= global_x_i;
    global_y_r_o <= global_y_i;
  end

  assign reset_o    = reset_r_o;
  assign global_x_o = global_x_r_o;
  // tile below sits one row further down
  assign global_y_o = y_cord_width_c'(global_y_r_o + 1'b1);

  // north or south half, then column within the ruche group
  assign my_cid_o = {~global_y_r_o[y_cord_width_c-1], global_x_r_o[0]};

  assert property (@(posedge clk_i) reset_r_o && $past(reset_r_o) |-> $stable(global_x_r_o))
    else $error("x coordinate moved while the tile was held in reset");

endmodule

// File: logic/link_to_cache.sv
// ####################################################################
// link adapter: queues network requests, returns cache results
// ####################################################################
`timescale 1ns/1ps

module link_to_cache #(
  parameter int req_fifo_els_p = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  vcache_pkg::link_pkt_s               link_req_i,
  output logic                                link_req_ready_o,
  output vcache_pkg::link_rsp_s               link_rsp_o,
  input  logic                                link_rsp_ready_i,
  output vcache_pkg::cache_pkt_s              cache_pkt_o,
  output logic                                cache_v_o,
  input  logic                                cache_ready_i,
  input  logic [vcache_pkg::data_width_c-1:0] cache_data_i,
  input  logic                                cache_data_v_i,
  output logic                                cache_yumi_o,
  output logic                                dest_east_o
);
  import vcache_pkg::*;

  localparam int ptr_w_lp = (req_fifo_els_p > 1) ? $clog2(req_fifo_els_p) : 1;
  localparam int cnt_w_lp = $clog2(req_fifo_els_p + 1);

  link_pkt_s                 queue_r [req_fifo_els_p];
  logic [ptr_w_lp-1:0]       wr_ptr_r, iss_ptr_r, rsp_ptr_r;
  logic [cnt_w_lp-1:0]       num_q_r, num_iss_r;
  logic                      rsp_v_r;
  logic [data_width_c-1:0]   rsp_data_r;
  logic [x_cord_width_c-1:0] rsp_x_r;
  logic [y_cord_width_c-1:0] rsp_y_r;
  logic                      enq, iss, deq;
  link_pkt_s                 head;

  function automatic logic [ptr_w_lp-1:0] bump(input logic [ptr_w_lp-1:0] p);
    return (p == ptr_w_lp'(req_fifo_els_p - 1)) ? '0 : p + 1'b1;
  endfunction

  assign link_req_ready_o = num_q_r < cnt_w_lp'(req_fifo_els_p);
  assign enq = link_req_i.v && link_req_ready_o;

  // entries past the issue pointer still wait for the cache
  assign head        = queue_r[iss_ptr_r];
  assign cache_v_o   = num_q_r > num_iss_r;
  assign cache_pkt_o = '{op: head.op, addr: head.addr, data: head.data};
  assign iss         = cache_v_o && cache_ready_i;

  // take the result once the response slot is free
  assign cache_yumi_o = cache_data_v_i && (!rsp_v_r || link_rsp_ready_i);
  assign deq = cache_yumi_o;

  assign link_rsp_o = '{v: rsp_v_r, data: rsp_data_r, dst_x: rsp_x_r, dst_y: rsp_y_r};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_r    <= '0;
      iss_ptr_r   <= '0;
      rsp_ptr_r   <= '0;
      num_q_r     <= '0;
      num_iss_r   <= '0;
      rsp_v_r     <= 1'b0;
      dest_east_o <= 1'b0;
    end else begin
      if (enq) wr_ptr_r <= bump(wr_ptr_r);
      if (iss) iss_ptr_r <= bump(iss_ptr_r);
      if (deq) rsp_ptr_r <= bump(rsp_ptr_r);
      num_q_r   <= num_q_r + cnt_w_lp'(enq) - cnt_w_lp'(deq);
      num_iss_r <= num_iss_r + cnt_w_lp'(iss) - cnt_w_lp'(deq);
      if (deq) rsp_v_r <= 1'b1;
      else if (link_rsp_ready_i) rsp_v_r <= 1'b0;
      // high half of the address space lives east
      if (iss) dest_east_o <= head.addr[addr_width_c-1];
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) queue_r[wr_ptr_r] <= link_req_i;
    if (deq) begin
      rsp_data_r <= cache_data_i;
      rsp_x_r    <= queue_r[rsp_ptr_r].src_x;
      rsp_y_r    <= queue_r[rsp_ptr_r].src_y;
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
    (num_q_r <= cnt_w_lp'(req_fifo_els_p)) && (num_iss_r <= num_q_r))
    else $error("request queue overflow");

endmodule

// File: logic/vcache_core.sv
// ####################################################################
// direct-mapped write-back cache with a DMA miss path
// ####################################################################
`timescale 1ns/1ps

module vcache_core #(
  parameter int sets_p        = 8,
  parameter int block_words_p = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  vcache_pkg::cache_pkt_s              cache_pkt_i,
  input  logic                                cache_v_i,
  output logic                                cache_ready_o,
  output logic [vcache_pkg::data_width_c-1:0] cache_data_o,
  output logic                                cache_data_v_o,
  input  logic                                cache_yumi_i,
  output vcache_pkg::dma_pkt_s                dma_pkt_o,
  output logic                                dma_pkt_v_o,
  input  logic                                dma_pkt_yumi_i,
  input  logic [vcache_pkg::data_width_c-1:0] fill_data_i,
  input  logic                                fill_v_i,
  output logic                                fill_ready_o,
  output logic [vcache_pkg::data_width_c-1:0] wb_data_o,
  output logic                                wb_v_o,
  input  logic                                wb_yumi_i
);
  import vcache_pkg::*;

  localparam int offset_w_lp = $clog2(block_words_p);
  localparam int index_w_lp  = $clog2(sets_p);
  localparam int tag_w_lp    = addr_width_c - index_w_lp - offset_w_lp;

  logic [data_width_c-1:0] data_mem [sets_p*block_words_p];
  logic [tag_w_lp-1:0]     tag_mem [sets_p];
  logic [sets_p-1:0]       valid_r, dirty_r;
  cache_state_e            state_r;
  cache_pkt_s              req_r;
  logic [offset_w_lp-1:0]  cnt_r;
  logic [data_width_c-1:0] rsp_data_r;

  logic [tag_w_lp-1:0]    tag;
  logic [index_w_lp-1:0]  idx;
  logic [offset_w_lp-1:0] off;
  logic                   hit, victim_dirty, last_word, is_store;

  // word address splits into tag, set and word offset
  assign {tag, idx, off} = req_r.addr;
  assign hit          = valid_r[idx] && (tag_mem[idx] == tag);
  assign victim_dirty = valid_r[idx] && dirty_r[idx];
  assign last_word    = cnt_r == offset_w_lp'(block_words_p - 1);
  assign is_store     = req_r.op == e_store;

  assign cache_ready_o  = state_r == e_idle;
  assign cache_data_v_o = state_r == e_respond;
  assign cache_data_o   = rsp_data_r;

  // dirty victim goes out first, the new block is read after it
  assign dma_pkt_v_o = (state_r == e_lookup) && !hit;
  assign dma_pkt_o = '{write_not_read: victim_dirty,
                       addr: {victim_dirty ? tag_mem[idx] : tag, idx, {offset_w_lp{1'b0}}}};

  assign wb_v_o       = state_r == e_writeback;
  assign wb_data_o    = data_mem[{idx, cnt_r}];
  assign fill_ready_o = state_r == e_fill;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= e_idle;
      valid_r <= '0;
      dirty_r <= '0;
      cnt_r   <= '0;
    end else begin
      unique case (state_r)
        e_idle: begin
          if (cache_v_i) state_r <= e_lookup;
        end
        e_lookup: begin
          if (hit) begin
            state_r <= e_respond;
            if (is_store) dirty_r[idx] <= 1'b1;
          end else if (dma_pkt_yumi_i) begin
            state_r <= victim_dirty ? e_writeback : e_fill;
            cnt_r   <= '0;
          end
        end
        e_writeback: begin
          if (wb_yumi_i) begin
            cnt_r <= cnt_r + 1'b1;
            // line now clean, so the retried lookup asks for a read
            if (last_word) begin
              dirty_r[idx] <= 1'b0;
              state_r      <= e_lookup;
            end
          end
        end
        e_fill: begin
          if (fill_v_i) begin
            cnt_r <= cnt_r + 1'b1;
            if (last_word) begin
              valid_r[idx] <= 1'b1;
              state_r      <= e_lookup;
            end
          end
        end
        e_respond: begin
          if (cache_yumi_i) state_r <= e_idle;
        end
        default: state_r <= e_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (cache_ready_o && cache_v_i) req_r <= cache_pkt_i;
    if (state_r == e_lookup && hit) begin
      rsp_data_r <= is_store ? '0 : data_mem[{idx, off}];
      if (is_store) data_mem[{idx, off}] <= req_r.data;
    end
    if (fill_ready_o && fill_v_i) begin
      data_mem[{idx, cnt_r}] <= fill_data_i;
      if (last_word) tag_mem[idx] <= tag;
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i) fill_v_i |-> state_r == e_fill)
    else $error("fill word arrived outside a fill");

endmodule

// File: logic/cache_dma_to_wormhole.sv
// ####################################################################
// DMA to wormhole converter: frames requests, strips fill headers
// ####################################################################
`timescale 1ns/1ps

module cache_dma_to_wormhole #(
  parameter int block_words_p = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  vcache_pkg::dma_pkt_s                  dma_pkt_i,
  input  logic                                  dma_pkt_v_i,
  output logic                                  dma_pkt_yumi_o,
  input  logic [vcache_pkg::data_width_c-1:0]   wb_data_i,
  input  logic                                  wb_v_i,
  output logic                                  wb_yumi_o,
  output logic [vcache_pkg::data_width_c-1:0]   fill_data_o,
  output logic                                  fill_v_o,
  input  logic                                  fill_ready_i,
  input  logic                                  dest_east_i,
  input  logic [vcache_pkg::wh_cid_width_c-1:0] my_cid_i,
  output logic [vcache_pkg::data_width_c-1:0]   wh_flit_o,
  output logic                                  wh_v_o,
  input  logic                                  wh_ready_i,
  input  logic [vcache_pkg::data_width_c-1:0]   wh_flit_i,
  input  logic                                  wh_v_i,
  output logic                                  wh_ready_o
);
  import vcache_pkg::*;

  localparam int send_w_lp = $clog2(block_words_p + 2);
  localparam int recv_w_lp = $clog2(block_words_p + 1);

  dma_pkt_s             pkt_r;
  logic                 send_busy_r;
  logic [send_w_lp-1:0] send_cnt_r;
  logic [recv_w_lp-1:0] recv_cnt_r;
  wh_hdr_s              hdr_out, hdr_in;
  logic                 data_phase, flit_sent, send_last;

  assign dma_pkt_yumi_o = dma_pkt_v_i && !send_busy_r;

  assign hdr_out = '{dest_cord: {wh_cord_width_c{dest_east_i}},
                     len: pkt_r.write_not_read ? wh_len_width_c'(block_words_p + 1)
                                               : wh_len_width_c'(1),
                     cid: my_cid_i,
                     write_not_read: pkt_r.write_not_read,
                     pad: '0};

  // header at 0, address at 1, write-back words after that
  assign data_phase = send_cnt_r > send_w_lp'(1);
  assign wh_v_o     = send_busy_r && (!data_phase || wb_v_i);
  assign flit_sent  = wh_v_o && wh_ready_i;
  assign wb_yumi_o  = flit_sent && data_phase;
  assign send_last  = pkt_r.write_not_read ? (send_cnt_r == send_w_lp'(block_words_p + 1))
                                           : (send_cnt_r == send_w_lp'(1));

  always_comb begin
    if (send_cnt_r == '0) wh_flit_o = hdr_out;
    else if (!data_phase) wh_flit_o = data_width_c'(pkt_r.addr);
    else wh_flit_o = wb_data_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      send_busy_r <= 1'b0;
      send_cnt_r  <= '0;
    end else if (dma_pkt_yumi_o) begin
      send_busy_r <= 1'b1;
      send_cnt_r  <= '0;
    end else if (flit_sent) begin
      send_cnt_r <= send_cnt_r + 1'b1;
      if (send_last) send_busy_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dma_pkt_yumi_o) pkt_r <= dma_pkt_i;
  end

  // returned header is swallowed, data words go to the cache
  assign hdr_in      = wh_hdr_s'(wh_flit_i);
  assign wh_ready_o  = (recv_cnt_r == '0) || fill_ready_i;
  assign fill_v_o    = wh_v_i && (recv_cnt_r != '0);
  assign fill_data_o = wh_flit_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      recv_cnt_r <= '0;
    end else if (wh_v_i && wh_ready_o) begin
      recv_cnt_r <= (recv_cnt_r == recv_w_lp'(block_words_p)) ? '0 : recv_cnt_r + 1'b1;
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
    wh_v_i && (recv_cnt_r == '0) |-> hdr_in.len == wh_len_width_c'(block_words_p))
    else $error("fill frame length differs from the block size");

endmodule

// File: logic/vcache_tile.sv
// ####################################################################
// vcache tile top: control, link adapter, cache and DMA converter
// ####################################################################
`timescale 1ns/1ps

module vcache_tile #(
  parameter int sets_p         = 8,
  parameter int block_words_p  = 4,
  parameter int req_fifo_els_p = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  output logic                                  reset_o,
  input  vcache_pkg::link_pkt_s                 link_req_i,
  output logic                                  link_req_ready_o,
  output vcache_pkg::link_rsp_s                 link_rsp_o,
  input  logic                                  link_rsp_ready_i,
  output logic [vcache_pkg::data_width_c-1:0]   wh_flit_o,
  output logic                                  wh_v_o,
  input  logic                                  wh_ready_i,
  input  logic [vcache_pkg::data_width_c-1:0]   wh_flit_i,
  input  logic                                  wh_v_i,
  output logic                                  wh_ready_o,
  input  logic [vcache_pkg::x_cord_width_c-1:0] global_x_i,
  input  logic [vcache_pkg::y_cord_width_c-1:0] global_y_i,
  output logic [vcache_pkg::x_cord_width_c-1:0] global_x_o,
  output logic [vcache_pkg::y_cord_width_c-1:0] global_y_o
);
  import vcache_pkg::*;

  logic                      reset_r;
  logic [wh_cid_width_c-1:0] my_cid;
  cache_pkt_s                cache_pkt;
  logic                      cache_v, cache_ready;
  logic [data_width_c-1:0]   cache_data;
  logic                      cache_data_v, cache_yumi, dest_east;
  dma_pkt_s                  dma_pkt;
  logic                      dma_pkt_v, dma_pkt_yumi;
  logic [data_width_c-1:0]   fill_data, wb_data;
  logic                      fill_v, fill_ready, wb_v, wb_yumi;

  vcache_tile_ctrl ctrl_i (
    .clk_i(clk_i), .rst_i(rst_i),
    .global_x_i(global_x_i), .global_y_i(global_y_i),
    .reset_r_o(reset_r), .reset_o(reset_o),
    .global_x_r_o(), .global_y_r_o(),
    .global_x_o(global_x_o), .global_y_o(global_y_o),
    .my_cid_o(my_cid)
  );

  link_to_cache #(.req_fifo_els_p(req_fifo_els_p)) link_i (
    .clk_i(clk_i), .rst_i(reset_r),
    .link_req_i(link_req_i), .link_req_ready_o(link_req_ready_o),
    .link_rsp_o(link_rsp_o), .link_rsp_ready_i(link_rsp_ready_i),
    .cache_pkt_o(cache_pkt), .cache_v_o(cache_v), .cache_ready_i(cache_ready),
    .cache_data_i(cache_data), .cache_data_v_i(cache_data_v), .cache_yumi_o(cache_yumi),
    .dest_east_o(dest_east)
  );

  vcache_core #(.sets_p(sets_p), .block_words_p(block_words_p)) core_i (
    .clk_i(clk_i), .rst_i(reset_r),
    .cache_pkt_i(cache_pkt), .cache_v_i(cache_v), .cache_ready_o(cache_ready),
    .cache_data_o(cache_data), .cache_data_v_o(cache_data_v), .cache_yumi_i(cache_yumi),
    .dma_pkt_o(dma_pkt), .dma_pkt_v_o(dma_pkt_v), .dma_pkt_yumi_i(dma_pkt_yumi),
    .fill_data_i(fill_data), .fill_v_i(fill_v), .fill_ready_o(fill_ready),
    .wb_data_o(wb_data), .wb_v_o(wb_v), .wb_yumi_i(wb_yumi)
  );

  cache_dma_to_wormhole #(.block_words_p(block_words_p)) dma_i (
    .clk_i(clk_i), .rst_i(reset_r),
    .dma_pkt_i(dma_pkt), .dma_pkt_v_i(dma_pkt_v), .dma_pkt_yumi_o(dma_pkt_yumi),
    .wb_data_i(wb_data), .wb_v_i(wb_v), .wb_yumi_o(wb_yumi),
    .fill_data_o(fill_data), .fill_v_o(fill_v), .fill_ready_i(fill_ready),
    .dest_east_i(dest_east), .my_cid_i(my_cid),
    .wh_flit_o(wh_flit_o), .wh_v_o(wh_v_o), .wh_ready_i(wh_ready_i),
    .wh_flit_i(wh_flit_i), .wh_v_i(wh_v_i), .wh_ready_o(wh_ready_o)
  );

endmodule

// File: verif/vcache_tile_tb.sv
// ####################################################################
// vcache tile testbench: file-driven requests, wormhole memory model
// ####################################################################
`timescale 1ns/1ps

module vcache_tile_tb;
  import vcache_pkg::*;

  localparam int sets_p         = 8;
  localparam int block_words_p  = 4;
  localparam int req_fifo_els_p = 4;
  localparam int wait_limit_c   = 2000;
  localparam int quiet_cycles_c = 20;

  typedef struct packed {
    logic [data_width_c-1:0]   data;
    logic [x_cord_width_c-1:0] x;
    logic [y_cord_width_c-1:0] y;
  } exp_rsp_s;

  logic                      clk_i, rst_i, reset_o;
  link_pkt_s                 link_req_i;
  logic                      link_req_ready_o;
  link_rsp_s                 link_rsp_o;
  logic                      link_rsp_ready_i;
  logic [data_width_c-1:0]   wh_flit_o, wh_flit_i;
  logic                      wh_v_o, wh_ready_i, wh_v_i, wh_ready_o;
  logic [x_cord_width_c-1:0] global_x_i, global_x_o;
  logic [y_cord_width_c-1:0] global_y_i, global_y_o;

  integer                    seed = 32'h844e5b96;
  logic [data_width_c-1:0]   mem [1 << addr_width_c];
  exp_rsp_s                  exp_q [$];
  logic [data_width_c-1:0]   tx_q [$];
  int                        rx_cnt, rd_frames, wr_frames;
  wh_hdr_s                   rx_hdr;
  logic [addr_width_c-1:0]   rx_addr;

  vcache_tile #(
    .sets_p(sets_p), .block_words_p(block_words_p), .req_fifo_els_p(req_fifo_els_p)
  ) dut_i (
    .clk_i(clk_i), .rst_i(rst_i), .reset_o(reset_o),
    .link_req_i(link_req_i), .link_req_ready_o(link_req_ready_o),
    .link_rsp_o(link_rsp_o), .link_rsp_ready_i(link_rsp_ready_i),
    .wh_flit_o(wh_flit_o), .wh_v_o(wh_v_o), .wh_ready_i(wh_ready_i),
    .wh_flit_i(wh_flit_i), .wh_v_i(wh_v_i), .wh_ready_o(wh_ready_o),
    .global_x_i(global_x_i), .global_y_i(global_y_i),
    .global_x_o(global_x_o), .global_y_o(global_y_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
  endtask

  // random stall on both output links
  always @(posedge clk_i) begin
    if (rst_i) begin
      wh_ready_i       <= 1'b1;
      link_rsp_ready_i <= 1'b1;
    end else begin
      wh_ready_i       <= ($random(seed) & 3) != 0;
      link_rsp_ready_i <= ($random(seed) & 3) != 0;
    end
  end

  // wormhole memory: frames in, fill frames out
  always @(posedge clk_i) begin
    if (!rst_i && wh_v_o && wh_ready_i) begin
      if (rx_cnt == 0) begin
        rx_hdr = wh_hdr_s'(wh_flit_o);
        assert (rx_hdr.cid == {~global_y_i[y_cord_width_c-1], global_x_i[0]})
          else stop_on_error($sformatf("Mismatch cid: got %h expected %h", rx_hdr.cid,
                             {~global_y_i[y_cord_width_c-1], global_x_i[0]}));
        assert (rx_hdr.len == (rx_hdr.write_not_read ? block_words_p + 1 : 1))
          else stop_on_error($sformatf("Mismatch len: got %h for write bit %h",
                             rx_hdr.len, rx_hdr.write_not_read));
        rx_cnt = 1;
      end else if (rx_cnt == 1) begin
        rx_addr = wh_flit_o[addr_width_c-1:0];
        assert (rx_addr % block_words_p == 0)
          else stop_on_error($sformatf("Mismatch frame_addr: got %h, not block aligned",
                             rx_addr));
        if (rx_hdr.write_not_read) begin
          rx_cnt = 2;
        end else begin
          assert (rx_hdr.dest_cord == {wh_cord_width_c{rx_addr[addr_width_c-1]}})
            else stop_on_error($sformatf("Mismatch dest_cord: got %h for address %h",
                               rx_hdr.dest_cord, rx_addr));
          tx_q.push_back(data_width_c'(wh_hdr_s'{dest_cord: '0,
                                                 len: wh_len_width_c'(block_words_p),
                                                 cid: '0, write_not_read: 1'b0, pad: '0}));
          for (int i = 0; i < block_words_p; i++) begin
            tx_q.push_back(mem[rx_addr + i]);
          end
          rd_frames++;
          rx_cnt = 0;
        end
      end else begin
        mem[rx_addr + rx_cnt - 2] = wh_flit_o;
        if (rx_cnt == block_words_p + 1) begin
          wr_frames++;
          rx_cnt = 0;
        end else begin
          rx_cnt++;
        end
      end
    end
    if (rst_i) begin
      tx_q.delete();
      wh_v_i <= 1'b0;
    end else begin
      if (wh_v_i && wh_ready_o) void'(tx_q.pop_front());
      if (tx_q.size() > 0) begin
        wh_v_i    <= 1'b1;
        wh_flit_i <= tx_q[0];
      end else begin
        wh_v_i <= 1'b0;
      end
    end
  end

  // responses must come back in request order
  always @(posedge clk_i) begin
    if (!rst_i && link_rsp_o.v && link_rsp_ready_i) begin
      assert (exp_q.size() > 0)
        else stop_on_error("a response arrived with no request outstanding");
      assert (link_rsp_o.data == exp_q[0].data)
        else stop_on_error($sformatf("Mismatch link_rsp_o.data: got %h expected %h",
                           link_rsp_o.data, exp_q[0].data));
      assert (link_rsp_o.dst_x == exp_q[0].x && link_rsp_o.dst_y == exp_q[0].y)
        else stop_on_error($sformatf("Mismatch link_rsp_o.dst: got %h/%h expected %h/%h",
                           link_rsp_o.dst_x, link_rsp_o.dst_y, exp_q[0].x, exp_q[0].y));
      void'(exp_q.pop_front());
    end
  end

  task automatic check_reset_out(input logic exp);
    @(negedge clk_i);
    assert (reset_o === exp)
      else stop_on_error($sformatf("Mismatch reset_o: got %h expected %h", reset_o, exp));
  endtask

  task automatic check_coords(input logic [x_cord_width_c-1:0] x,
                              input logic [y_cord_width_c-1:0] y);
    @(posedge clk_i);
    global_x_i <= x;
    global_y_i <= y;
    @(posedge clk_i);
    @(negedge clk_i);
    assert (global_x_o == x)
      else stop_on_error($sformatf("Mismatch global_x_o: got %h expected %h", global_x_o, x));
    assert (global_y_o == y_cord_width_c'(y + 1))
      else stop_on_error($sformatf("Mismatch global_y_o: got %h expected %h", global_y_o,
                         y_cord_width_c'(y + 1)));
  endtask

  task automatic send_request(input logic op, input logic [addr_width_c-1:0] addr,
                              input logic [data_width_c-1:0] data,
                              input logic [data_width_c-1:0] exp, input int n);
    int  waited;
    bit  taken;
    link_pkt_s pkt;
    pkt = '{v: 1'b1, op: link_op_e'(op), addr: addr, data: data,
            src_x: x_cord_width_c'(n), src_y: y_cord_width_c'(n + 3)};
    link_req_i <= pkt;
    taken  = 0;
    waited = 0;
    while (!taken) begin
      @(negedge clk_i);
      if (link_req_ready_o) begin
        taken = 1;
      end else begin
        waited++;
        if (waited > wait_limit_c) stop_on_error("request was never accepted");
      end
    end
    exp_q.push_back('{data: exp, x: pkt.src_x, y: pkt.src_y});
    @(posedge clk_i);
  endtask

  initial begin
    int fd, r, n, waited;
    string line;
    logic [3:0] op_v;
    logic [addr_width_c-1:0] addr_v;
    logic [data_width_c-1:0] data_v, exp_v;
    rst_i = 1'b1;
    link_req_i = '0;
    link_rsp_ready_i = 1'b1;
    wh_ready_i = 1'b1;
    wh_v_i = 1'b0;
    wh_flit_i = '0;
    global_x_i = 4'h5;
    global_y_i = 3'h2;
    rx_cnt = 0;
    rd_frames = 0;
    wr_frames = 0;
    for (int i = 0; i < (1 << addr_width_c); i++) mem[i] = '0;
    repeat (2) @(posedge clk_i);
    check_reset_out(1'b1);
    @(posedge clk_i);
    rst_i <= 1'b0;
    // registered reset lags the input by one clock
    check_reset_out(1'b1);
    check_reset_out(1'b0);
    @(posedge clk_i);
    @(negedge clk_i);
    assert (!link_rsp_o.v && !wh_v_o && link_req_ready_o && wh_ready_o)
      else stop_on_error("link or wormhole handshake outputs wrong after reset");
    check_coords(4'h3, 3'h7);
    check_coords(4'ha, 3'h0);
    check_coords(4'h5, 3'h2);
    fd = $fopen("verif/vcache_tile_tests.txt", "r");
    if (fd == 0) stop_on_error("could not open the test data file");
    n = 0;
    @(posedge clk_i);
    while (!$feof(fd)) begin
      r = $fgets(line, fd);
      if (r == 0 || line.len() == 0 || line.substr(0, 0) == "#") continue;
      r = $sscanf(line, "%h %h %h %h", op_v, addr_v, data_v, exp_v);
      if (r != 4) continue;
      send_request(op_v[0], addr_v, data_v, exp_v, n);
      n++;
    end
    $fclose(fd);
    link_req_i <= '0;
    waited = 0;
    while (exp_q.size() > 0) begin
      @(negedge clk_i);
      waited++;
      if (waited > wait_limit_c) stop_on_error("timed out waiting for responses");
    end
    // every request answered, so the response link stays quiet
    repeat (quiet_cycles_c) begin
      @(negedge clk_i);
      assert (!link_rsp_o.v)
        else stop_on_error($sformatf("Mismatch link_rsp_o.v: got %h expected 0",
                           link_rsp_o.v));
    end
    assert (rd_frames > 0 && wr_frames > 0)
      else stop_on_error("no read frame or no write-back frame was seen");
    $display("test passed");
    $finish;
  end

endmodule

// File: verif/vcache_tile_tests.txt
# op addr data expected, all hex; op 0 is a load, 1 is a store
# sets 8, block 4: set index is address bits 4:2
0 0010 00000000 00000000
1 0011 a5a50001 00000000
0 0011 00000000 a5a50001
1 8013 cafe0002 00000000
0 0011 00000000 a5a50001
0 8013 00000000 cafe0002
0 8012 00000000 00000000
1 0020 11110003 00000000
1 0024 22220004 00000000
1 0041 33330005 00000000
0 0420 00000000 00000000
0 0020 00000000 11110003
0 0024 00000000 22220004
1 c07f 44440006 00000000
0 007f 00000000 00000000
0 c07f 00000000 44440006
0 0041 00000000 33330005
1 0041 55550007 00000000
0 0041 00000000 55550007
0 9999 00000000 00000000
0 0010 00000000 00000000
0 8010 00000000 00000000

// File: tb.f
logic/vcache_pkg.sv
logic/vcache_tile_ctrl.sv
logic/link_to_cache.sv
logic/vcache_core.sv
logic/cache_dma_to_wormhole.sv
logic/vcache_tile.sv
verif/vcache_tile_tb.sv
